/* src/isaPkg.sv */
package isaPkg;

    // **************************************************
    // Instruction field positions
    // **************************************************
    localparam int opHi    = 31;
    localparam int opLo    = 26;
    localparam int rsHi    = 25;
    localparam int rsLo    = 21;
    localparam int rtHi    = 20;
    localparam int rtLo    = 16;
    localparam int rdHi    = 15;
    localparam int rdLo    = 11;
    localparam int functHi = 5;
    localparam int functLo = 0;
    localparam int immHi   = 15;
    localparam int immLo   = 0;

    // **************************************************
    // Primary opcodes
    // **************************************************
    localparam logic [5:0] opSpecial = 6'h00; // R-type, see function codes
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // Function codes under opSpecial
    localparam logic [5:0] fnMult = 6'h18;
    localparam logic [5:0] fnDiv  = 6'h1a;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;

endpackage

/* src/uopPkg.sv */
package uopPkg;

    // **************************************************
    // Micro-op kinds
    // **************************************************
    typedef enum logic [3:0] {
        addU     = 4'd0,
        subU     = 4'd1,
        addiU    = 4'd2,
        orI      = 4'd3,
        load     = 4'd4,
        store    = 4'd5,
        branchEq = 4'd6,
        multLo   = 4'd7,
        multHi   = 4'd8,
        divLo    = 4'd9,
        divHi    = 4'd10,
        mdBubble = 4'd11, // Filler between two decoders' micro-ops
        reserved = 4'd12
    } uopKind;

    typedef enum logic {
        typeNormal = 1'b0,
        typeCond   = 1'b1
    } branchType;

    // **************************************************
    // One micro-op as handed to rename
    // **************************************************
    typedef struct packed {
        uopKind      kind;
        logic [31:0] pc;
        logic        isDs;     // Sits in a branch delay slot
        branchType   brType;
        logic [4:0]  src0;
        logic [4:0]  src1;
        logic [4:0]  dst;
        logic        dstWe;
        logic [15:0] imm;
        logic        causeExc; // Reserved instruction
        logic        valid;
    } uopBundle;

endpackage

/* src/instDecoder.sv */
`timescale 1ns/1ps

module instDecoder import isaPkg::*, uopPkg::*; (
    input  logic        instValid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        isDs,
    output uopBundle    uop0,
    output uopBundle    uop1
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic        isMd;   // Cracks into a LO and a HI half
    logic        isRsvd;
    uopKind      hiKind;

    assign opcode = inst[opHi:opLo];
    assign rs     = inst[rsHi:rsLo];
    assign rt     = inst[rtHi:rtLo];
    assign rd     = inst[rdHi:rdLo];
    assign funct  = inst[functHi:functLo];
    assign imm    = inst[immHi:immLo];

    // **************************************************
    // First micro-op
    // **************************************************
    always_comb begin
        uop0        = '0;
        uop0.pc     = pc;
        uop0.isDs   = isDs;
        uop0.brType = typeNormal;
        uop0.imm    = imm;
        uop0.src0   = rs;
        uop0.src1   = rt;
        uop0.valid  = instValid;
        isMd        = 1'b0;
        isRsvd      = 1'b0;
        hiKind      = multHi;

        case (opcode)
            opSpecial: begin
                case (funct)
                    fnAddu: begin
                        uop0.kind  = addU;
                        uop0.dst   = rd;
                        uop0.dstWe = 1'b1;
                    end
                    fnSubu: begin
                        uop0.kind  = subU;
                        uop0.dst   = rd;
                        uop0.dstWe = 1'b1;
                    end
                    fnMult: begin
                        uop0.kind = multLo; // HI/LO only, no GPR write
                        isMd      = 1'b1;
                        hiKind    = multHi;
                    end
                    fnDiv: begin
                        uop0.kind = divLo;
                        isMd      = 1'b1;
                        hiKind    = divHi;
                    end
                    default: isRsvd = 1'b1;
                endcase
            end
            opAddiu: begin
                uop0.kind  = addiU;
                uop0.src1  = 5'd0;
                uop0.dst   = rt;
                uop0.dstWe = 1'b1;
            end
            opOri: begin
                uop0.kind  = orI;
                uop0.src1  = 5'd0;
                uop0.dst   = rt;
                uop0.dstWe = 1'b1;
            end
            opLw: begin
                uop0.kind  = load;
                uop0.src1  = 5'd0;
                uop0.dst   = rt;
                uop0.dstWe = 1'b1;
            end
            opSw:  uop0.kind = store; // Base in rs, data in rt
            opBeq: begin
                uop0.kind   = branchEq;
                uop0.brType = typeCond;
            end
            default: isRsvd = 1'b1;
        endcase

        if (isRsvd) begin
            uop0.kind     = reserved;
            uop0.src0     = 5'd0;
            uop0.src1     = 5'd0;
            uop0.causeExc = 1'b1;
        end
    end

    // Second half only for mult and div
    always_comb begin
        uop1 = '0;
        if (isMd) begin
            uop1      = uop0;
            uop1.kind = hiKind;
        end
    end

    always_comb begin
        assert (!uop1.valid || uop0.valid)
            else $error("instDecoder: second micro-op valid without first");
    end

endmodule

/* src/decodeRenameRegs.sv */
`timescale 1ns/1ps

module decodeRenameRegs import uopPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     pause,
    input  logic     flush,
    input  uopBundle dec0Uop0,
    input  uopBundle dec0Uop1,
    input  uopBundle dec1Uop0,
    input  uopBundle dec1Uop1,
    output logic     pauseReq,
    output uopBundle renameUop0,
    output uopBundle renameUop1
);

    uopBundle r0, r1; // Decoder 0 pair
    uopBundle r2, r3; // Decoder 1 pair
    uopBundle bubble;
    logic     full;
    logic     split;  // Second regrouped cycle pending

    assign full     = (r1.valid || r3.valid) && !split;
    assign pauseReq = full;

    // **************************************************
    // Stage register
    // **************************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            r0    <= '0;
            r1    <= '0;
            r2    <= '0;
            r3    <= '0;
            split <= 1'b0;
        end else if (flush) begin
            r0    <= '0;
            r1    <= '0;
            r2    <= '0;
            r3    <= '0;
            split <= 1'b0;
        end else if (pause || full) begin
            split <= full || split; // Contents held
        end else begin
            r0    <= dec0Uop0;
            r1    <= dec0Uop1;
            r2    <= dec1Uop0;
            r3    <= dec1Uop1;
            split <= full;
        end
    end

    // Keeps decoder 1's micro-ops out of decoder 0's pair
    always_comb begin
        bubble        = '0;
        bubble.kind   = mdBubble;
        bubble.pc     = r2.pc;
        bubble.isDs   = r2.isDs;
        bubble.brType = typeNormal;
        bubble.valid  = 1'b1;
    end

    // **************************************************
    // Output regrouping
    // **************************************************
    always_comb begin
        if (split) begin
            renameUop0 = r2;
            renameUop1 = r3;
        end else if (full) begin
            renameUop0 = r0;
            renameUop1 = r1.valid ? r1 : bubble;
        end else begin
            renameUop0 = r0;
            renameUop1 = r2;
        end
    end

    // Regrouping never takes more than two cycles
    assert property (@(posedge clk) disable iff (!arstN)
        pauseReq && !pause && !flush |=> !pauseReq);

    // Fetch packs slot 0 first
    assert property (@(posedge clk) disable iff (!arstN)
        renameUop1.valid |-> renameUop0.valid);

endmodule

/* src/decodeTop.sv */
`timescale 1ns/1ps

module decodeTop import uopPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        pause,
    input  logic        flush,
    input  logic        instValid0,
    input  logic        instValid1,
    input  logic        isDs0,
    input  logic        isDs1,
    input  logic [31:0] inst0,
    input  logic [31:0] inst1,
    input  logic [31:0] pc0,
    input  logic [31:0] pc1,
    output logic        pauseReq,
    output uopBundle    renameUop0,
    output uopBundle    renameUop1
);

    uopBundle dec0Uop0;
    uopBundle dec0Uop1;
    uopBundle dec1Uop0;
    uopBundle dec1Uop1;

    // **************************************************
    // Decoders, one per fetch slot
    // **************************************************
    instDecoder dec0_i (
        .instValid (instValid0),
        .inst      (inst0),
        .pc        (pc0),
        .isDs      (isDs0),
        .uop0      (dec0Uop0),
        .uop1      (dec0Uop1)
    );

    instDecoder dec1_i (
        .instValid (instValid1),
        .inst      (inst1),
        .pc        (pc1),
        .isDs      (isDs1),
        .uop0      (dec1Uop0),
        .uop1      (dec1Uop1)
    );

    decodeRenameRegs regs_i (
        .clk        (clk),
        .arstN      (arstN),
        .pause      (pause),
        .flush      (flush),
        .dec0Uop0   (dec0Uop0),
        .dec0Uop1   (dec0Uop1),
        .dec1Uop0   (dec1Uop0),
        .dec1Uop1   (dec1Uop1),
        .pauseReq   (pauseReq),
        .renameUop0 (renameUop0),
        .renameUop1 (renameUop1)
    );

endmodule

/* verification/decodeTb.sv */
`timescale 1ns/1ps

module decodeTb import isaPkg::*, uopPkg::*; ();

    localparam int waitLimit = 20;

    logic        clk;
    logic        arstN;
    logic        pause;
    logic        flush;
    logic        instValid0;
    logic        instValid1;
    logic        isDs0;
    logic        isDs1;
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic        pauseReq;
    uopBundle    renameUop0;
    uopBundle    renameUop1;
    logic [31:0] rngState;

    decodeTop dut_i (
        .clk        (clk),
        .arstN      (arstN),
        .pause      (pause),
        .flush      (flush),
        .instValid0 (instValid0),
        .instValid1 (instValid1),
        .isDs0      (isDs0),
        .isDs1      (isDs1),
        .inst0      (inst0),
        .inst1      (inst1),
        .pc0        (pc0),
        .pc1        (pc1),
        .pauseReq   (pauseReq),
        .renameUop0 (renameUop0),
        .renameUop1 (renameUop1)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // **************************************************
    // Reference decoder
    // **************************************************
    function automatic void refDecode(input logic v, input logic [31:0] inst,
                                      input logic [31:0] pc, input logic ds,
                                      output uopBundle u0, output uopBundle u1);
        logic [5:0] op;
        logic [5:0] fn;
        op = inst[31:26];
        fn = inst[5:0];
        u0 = '0;
        u1 = '0;
        u0.pc = pc;
        u0.isDs = ds;
        u0.brType = typeNormal;
        u0.imm = inst[15:0];
        u0.valid = v;
        u0.src0 = inst[25:21];
        if (op == opSpecial && (fn == fnAddu || fn == fnSubu)) begin
            u0.kind = (fn == fnAddu) ? addU : subU;
            u0.src1 = inst[20:16];
            u0.dst = inst[15:11];
            u0.dstWe = 1'b1;
        end else if (op == opSpecial && (fn == fnMult || fn == fnDiv)) begin
            u0.kind = (fn == fnMult) ? multLo : divLo;
            u0.src1 = inst[20:16];
            u1 = u0;
            u1.kind = (fn == fnMult) ? multHi : divHi;
        end else if (op == opAddiu || op == opOri || op == opLw) begin
            u0.kind = (op == opAddiu) ? addiU : (op == opOri) ? orI : load;
            u0.dst = inst[20:16];
            u0.dstWe = 1'b1;
        end else if (op == opSw || op == opBeq) begin
            u0.kind = (op == opSw) ? store : branchEq;
            u0.src1 = inst[20:16];
            u0.brType = (op == opBeq) ? typeCond : typeNormal;
        end else begin
            u0.kind = reserved;
            u0.src0 = 5'd0;
            u0.causeExc = 1'b1;
        end
    endfunction

    function automatic uopBundle makeBubble(input logic [31:0] pc, input logic ds);
        uopBundle b;
        b = '0;
        b.kind = mdBubble;
        b.pc = pc;
        b.isDs = ds;
        b.brType = typeNormal;
        b.valid = 1'b1;
        return b;
    endfunction

    // Random fields around a given opcode or function code
    function automatic logic [31:0] randomInst(input int kindIdx);
        logic [31:0] r;
        r = nextRandom();
        case (kindIdx)
            0: return {opSpecial, r[25:6], fnAddu};
            1: return {opSpecial, r[25:6], fnSubu};
            2: return {opAddiu, r[25:0]};
            3: return {opOri, r[25:0]};
            4: return {opLw, r[25:0]};
            5: return {opSw, r[25:0]};
            6: return {opBeq, r[25:0]};
            7: return {opSpecial, r[25:6], fnMult};
            default: return {opSpecial, r[25:6], fnDiv};
        endcase
    endfunction

    // **************************************************
    // Checks and waits
    // **************************************************
    task automatic checkUop(input string name, input uopBundle exp, input uopBundle act);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            $display("FAIL: %s expected %h actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL: %s expected %b actual %b", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic waitOut(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (renameUop0.valid !== 1'b1) begin
            n++;
            if (n > waitLimit) begin
                $display("ERROR: %s: no valid output arrived in time", name);
                $display("FAIL: see errors above");
                $fatal(1);
            end
            @(negedge clk);
        end
    endtask

    task automatic drive(input logic v0, input logic [31:0] i0, input logic [31:0] p0,
                         input logic d0, input logic v1, input logic [31:0] i1,
                         input logic [31:0] p1, input logic d1);
        @(posedge clk);
        instValid0 <= v0;
        inst0      <= i0;
        pc0        <= p0;
        isDs0      <= d0;
        instValid1 <= v1;
        inst1      <= i1;
        pc1        <= p1;
        isDs1      <= d1;
    endtask

    task automatic idle();
        @(posedge clk);
        instValid0 <= 1'b0;
        instValid1 <= 1'b0;
    endtask

    // **************************************************
    // Tests
    // **************************************************
    task automatic testSimplePairs();
        logic [31:0] i0, i1;
        uopBundle e00, e01, e10, e11;
        for (int k = 0; k < 7; k++) begin
            i0 = randomInst(k);
            i1 = randomInst((k + 3) % 7);
            refDecode(1'b1, i0, 32'h1000 + 8 * k, 1'b0, e00, e01);
            refDecode(1'b1, i1, 32'h1004 + 8 * k, k[0], e10, e11);
            drive(1'b1, i0, 32'h1000 + 8 * k, 1'b0, 1'b1, i1, 32'h1004 + 8 * k, k[0]);
            idle();
            @(negedge clk); // One cycle of latency
            checkUop("simplePairs uop0", e00, renameUop0);
            checkUop("simplePairs uop1", e10, renameUop1);
            checkBit("simplePairs pauseReq", 1'b0, pauseReq);
        end
    endtask

    task automatic crackPair(input string name, input logic [31:0] i0,
                             input logic [31:0] i1, input logic v1);
        uopBundle e00, e01, e10, e11;
        refDecode(1'b1, i0, 32'h2000, 1'b0, e00, e01);
        refDecode(v1, i1, 32'h2004, 1'b1, e10, e11);
        drive(1'b1, i0, 32'h2000, 1'b0, v1, i1, 32'h2004, 1'b1);
        waitOut(name);
        checkBit({name, " pauseReq high"}, 1'b1, pauseReq);
        checkUop({name, " first uop0"}, e00, renameUop0);
        checkUop({name, " first uop1"}, e01.valid ? e01 : makeBubble(32'h2004, 1'b1),
                 renameUop1);
        idle(); // Inputs held up to this edge
        @(negedge clk);
        checkBit({name, " pauseReq low"}, 1'b0, pauseReq);
        checkUop({name, " second uop0"}, e10, renameUop0);
        checkUop({name, " second uop1"}, e11, renameUop1);
        @(negedge clk);
        checkUop({name, " drained"}, '0, renameUop0);
    endtask

    task automatic testCrackSecond();
        crackPair("crackSecond", randomInst(0), randomInst(7), 1'b1);
    endtask

    task automatic testCrackFirst();
        crackPair("crackFirstOri", randomInst(8), randomInst(3), 1'b1);
        crackPair("crackFirstDiv", randomInst(8), randomInst(8), 1'b1);
    endtask

    task automatic testReserved();
        logic [31:0] r;
        logic [31:0] i0;
        uopBundle e0, e1;
        r = nextRandom();
        i0 = {6'h3f, r[25:0]};
        refDecode(1'b1, i0, 32'h3000, 1'b0, e0, e1);
        drive(1'b1, i0, 32'h3000, 1'b0, 1'b0, 32'h0, 32'h3004, 1'b0);
        idle();
        @(negedge clk);
        checkUop("reserved uop0", e0, renameUop0);
        checkBit("reserved causeExc", 1'b1, renameUop0.causeExc);
        checkUop("reserved uop1", '0, renameUop1);
    endtask

    task automatic testPauseFlush();
        logic [31:0] i0, i1;
        uopBundle e00, e01, e10, e11;
        i0 = randomInst(8);
        i1 = randomInst(7);
        refDecode(1'b1, i0, 32'h4000, 1'b0, e00, e01);
        refDecode(1'b1, i1, 32'h4004, 1'b0, e10, e11);
        drive(1'b1, i0, 32'h4000, 1'b0, 1'b1, i1, 32'h4004, 1'b0);
        @(posedge clk); // Capture edge
        pause <= 1'b1;
        @(negedge clk);
        checkUop("pause first uop0", e00, renameUop0);
        checkUop("pause first uop1", e01, renameUop1);
        idle();
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            checkUop("pause held uop0", e10, renameUop0);
            checkUop("pause held uop1", e11, renameUop1);
        end
        @(posedge clk);
        pause <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        checkUop("pause released", '0, renameUop0);

        // Flush while the second half is pending
        drive(1'b1, i0, 32'h4000, 1'b0, 1'b1, i1, 32'h4004, 1'b0);
        waitOut("flush");
        checkBit("flush pauseReq", 1'b1, pauseReq);
        idle();
        flush <= 1'b1;
        @(negedge clk);
        checkUop("flush split uop0", e10, renameUop0);
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        checkUop("flush uop0", '0, renameUop0);
        checkUop("flush uop1", '0, renameUop1);
        checkBit("flush pauseReq low", 1'b0, pauseReq);
    endtask

    task automatic testReset();
        drive(1'b1, randomInst(7), 32'h5000, 1'b0, 1'b1, randomInst(1), 32'h5004, 1'b0);
        waitOut("reset");
        @(posedge clk);
        arstN      <= 1'b0;
        instValid0 <= 1'b0;
        instValid1 <= 1'b0;
        @(negedge clk);
        checkUop("reset uop0", '0, renameUop0);
        checkUop("reset uop1", '0, renameUop1);
        checkBit("reset pauseReq", 1'b0, pauseReq);
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
    endtask

    initial begin
        rngState   = 32'h23df6bea;
        arstN      = 1'b0;
        pause      = 1'b0;
        flush      = 1'b0;
        instValid0 = 1'b0;
        instValid1 = 1'b0;
        isDs0      = 1'b0;
        isDs1      = 1'b0;
        inst0      = 32'h0;
        inst1      = 32'h0;
        pc0        = 32'h0;
        pc1        = 32'h0;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        testSimplePairs();
        testCrackSecond();
        testCrackFirst();
        testReserved();
        testPauseFlush();
        testReset();

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* sim.f */
src/isaPkg.sv
src/uopPkg.sv
src/instDecoder.sv
src/decodeRenameRegs.sv
src/decodeTop.sv
verification/decodeTb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module decodeTb \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
